/* design/layer0_settings.svh */
`ifndef LAYER0_SETTINGS_SVH
`define LAYER0_SETTINGS_SVH

// Input image geometry
`define PIXEL_COUNT 144
`define PIXEL_WIDTH 8

// Width of every neuron sum, wraps in two's complement
`define ACC_WIDTH 20

// Neurons with at least one nonzero weight or bias
`define NEURON_COUNT 4

// Magnitude of one ternary weight step
`define WEIGHT_SCALE 59

`endif

/* design/layer0_pkg.sv */
`default_nettype none

`include "layer0_settings.svh"

package layer0_pkg;

  // Signed input pixel
  typedef logic signed [`PIXEL_WIDTH-1:0] pixel_t;

  // Signed neuron sum
  typedef logic signed [`ACC_WIDTH-1:0] acc_t;

  // Element 0 sits in the lowest byte
  typedef pixel_t [`PIXEL_COUNT-1:0] image_t;

  // One bit per pixel
  typedef logic [`PIXEL_COUNT-1:0] pixel_mask_t;

  // n2 in the lowest bits
  typedef struct packed {
    acc_t n15;
    acc_t n10;
    acc_t n5;
    acc_t n2;
  } layer_out_t;

  typedef enum logic [2:0] {
    w_zero,
    w_plus,
    w_minus,
    w_plus2,
    w_minus2
  } weight_code_e;

  // Mask with only the given pixel set
  function automatic pixel_mask_t px(input int idx);
    return pixel_mask_t'(1) << idx;
  endfunction

  // Neuron 2
  localparam pixel_mask_t n2_pos =
    px(61)  | px(69)  | px(73)  | px(74)  | px(75);

  localparam pixel_mask_t n2_neg =
    px(27)  | px(28)  | px(29)  | px(39)  | px(40)  |
    px(41)  | px(42)  | px(43)  | px(52)  | px(53)  |
    px(54)  | px(55)  | px(65)  | px(77)  | px(78)  |
    px(89)  | px(90)  | px(119) | px(120) | px(131) |
    px(132) | px(136) | px(142) | px(143);

  localparam pixel_mask_t n2_dbl = '0;

  // Neuron 5
  localparam pixel_mask_t n5_pos =
    px(36)  | px(37)  | px(46)  | px(47)  | px(48)  |
    px(49)  | px(58)  | px(59)  | px(61)  | px(62)  |
    px(70)  | px(72)  | px(74)  | px(75)  | px(80)  |
    px(84)  | px(88)  | px(95)  | px(96)  | px(107) |
    px(108) | px(119) | px(120) | px(131);

  localparam pixel_mask_t n5_neg =
    px(11)  | px(29)  | px(30)  | px(39)  | px(40)  |
    px(41)  | px(42)  | px(43)  | px(44)  | px(52)  |
    px(53)  | px(54)  | px(55)  | px(97)  | px(109) |
    px(118) | px(121) | px(126);

  // Pixel 42 weighs minus two steps
  localparam pixel_mask_t n5_dbl = px(42);

  // Neuron 10
  localparam pixel_mask_t n10_pos =
    px(1)   | px(23)  | px(135) | px(140);

  localparam pixel_mask_t n10_neg =
    px(69)  | px(73)  | px(80)  | px(87)  | px(94)  |
    px(108);

  localparam pixel_mask_t n10_dbl = '0;

  // Neuron 15
  localparam pixel_mask_t n15_pos =
    px(0)   | px(2)   | px(7)   | px(8)   | px(9)   |
    px(10)  | px(19)  | px(93)  | px(98)  | px(100) |
    px(101) | px(102) | px(103) | px(104) | px(105) |
    px(110) | px(111) | px(112) | px(113) | px(114) |
    px(115) | px(117) | px(123) | px(124) | px(127);

  localparam pixel_mask_t n15_neg =
    px(64)  | px(65)  | px(66)  | px(67)  | px(77)  |
    px(96)  | px(107) | px(108) | px(119) | px(120) |
    px(131) | px(132) | px(133) | px(141) | px(142) |
    px(143);

  localparam pixel_mask_t n15_dbl = px(132) | px(143);

  // Tables indexed by neuron, entry 0 is n2
  localparam pixel_mask_t pos_mask [`NEURON_COUNT] = '{
    n2_pos,
    n5_pos,
    n10_pos,
    n15_pos
  };

  localparam pixel_mask_t neg_mask [`NEURON_COUNT] = '{
    n2_neg,
    n5_neg,
    n10_neg,
    n15_neg
  };

  localparam pixel_mask_t dbl_mask [`NEURON_COUNT] = '{
    n2_dbl,
    n5_dbl,
    n10_dbl,
    n15_dbl
  };

  // Bias in weight steps
  localparam int signed bias_code [`NEURON_COUNT] = '{-1, 2, 4, 0};

  function automatic weight_code_e weight_of(input int neuron, input int pixel);
    weight_code_e code;
    code = w_zero;
    if (pos_mask[neuron][pixel])
    begin
      code = dbl_mask[neuron][pixel] ? w_plus2 : w_plus;
    end
    else if (neg_mask[neuron][pixel])
    begin
      code = dbl_mask[neuron][pixel] ? w_minus2 : w_minus;
    end
    return code;
  endfunction

endpackage

`default_nettype wire

/* design/pixel_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_buffer
(
  input  wire                clk,
  input  wire                rst,
  input  wire layer0_pkg::image_t img,
  output layer0_pkg::image_t pixels
);

  // Loads on every edge, valid plays no part here
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pixels <= '0;
    end
    else
    begin
      pixels <= img;
    end
  end

endmodule

`default_nettype wire

/* design/dense_neuron.sv */
`timescale 1ns/10ps
`default_nettype none

`include "layer0_settings.svh"

module dense_neuron
#(
  parameter int NEURON = 0
)
(
  input  wire layer0_pkg::image_t pixels,
  output layer0_pkg::acc_t        result
);

  // Bias as a sum value
  localparam layer0_pkg::acc_t bias_value =
    layer0_pkg::acc_t'(layer0_pkg::bias_code[NEURON] * `WEIGHT_SCALE);

  layer0_pkg::acc_t weighted;
  layer0_pkg::acc_t biased;

  // Every weight is a constant, so each case folds to one add or nothing
  always_comb
  begin
    layer0_pkg::pixel_t pix;
    layer0_pkg::acc_t   step;
    weighted = '0;
    for (int i = 0; i < `PIXEL_COUNT; i++)
    begin
      pix  = pixels[i];
      // One weight step for this pixel
      step = layer0_pkg::acc_t'(layer0_pkg::acc_t'(pix) * `WEIGHT_SCALE);
      case (layer0_pkg::weight_of(NEURON, i))
        layer0_pkg::w_plus:
        begin
          weighted = weighted + step;
        end
        layer0_pkg::w_minus:
        begin
          weighted = weighted - step;
        end
        layer0_pkg::w_plus2:
        begin
          weighted = weighted + (step <<< 1);
        end
        layer0_pkg::w_minus2:
        begin
          weighted = weighted - (step <<< 1);
        end
        default:
        begin
          // Zero weight
          weighted = weighted;
        end
      endcase
    end
  end

  // Wraps at ACC_WIDTH bits
  assign biased = weighted + bias_value;

  // ReLU on the sign bit
  assign result = biased[`ACC_WIDTH-1] ? '0 : biased;

endmodule

`default_nettype wire

/* design/layer0_dense.sv */
`timescale 1ns/10ps
`default_nettype none

`include "layer0_settings.svh"

module layer0_dense
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire layer0_pkg::image_t img,
  input  wire                     valid,
  output logic                    ready,
  output layer0_pkg::layer_out_t  layer_out
);

  layer0_pkg::image_t pixels;

  // Entry 0 is n2, then n5, n10, n15
  layer0_pkg::acc_t results [`NEURON_COUNT];

  pixel_buffer pixel_buffer_i
  (
    .clk    (clk),
    .rst    (rst),
    .img    (img),
    .pixels (pixels)
  );

  for (genvar n = 0; n < `NEURON_COUNT; n++)
  begin : gen_neuron
    dense_neuron
    #(
      .NEURON (n)
    )
    dense_neuron_i
    (
      .pixels (pixels),
      .result (results[n])
    );
  end

  assign layer_out.n2  = results[0];
  assign layer_out.n5  = results[1];
  assign layer_out.n10 = results[2];
  assign layer_out.n15 = results[3];

  // Sums are combinational, so ready only follows the buffer load
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ready <= 1'b0;
    end
    else
    begin
      ready <= valid;
    end
  end

endmodule

`default_nettype wire

/* test/layer0_model.svh */
`ifndef LAYER0_MODEL_SVH
`define LAYER0_MODEL_SVH

`include "layer0_settings.svh"

// Xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Signed weight in steps, read straight from the package masks
function automatic int weight_steps(input int neuron, input int pixel);
  int steps;
  steps = 0;
  if (layer0_pkg::pos_mask[neuron][pixel])
  begin
    steps = 1;
  end
  else if (layer0_pkg::neg_mask[neuron][pixel])
  begin
    steps = -1;
  end
  if (layer0_pkg::dbl_mask[neuron][pixel])
  begin
    steps = steps * 2;
  end
  return steps;
endfunction

function automatic layer0_pkg::acc_t model_neuron(input int neuron,
                                                  input layer0_pkg::image_t pixels);
  int                    sum;
  logic [`ACC_WIDTH-1:0] wrapped;
  sum = layer0_pkg::bias_code[neuron] * `WEIGHT_SCALE;
  for (int i = 0; i < `PIXEL_COUNT; i++)
  begin
    sum = sum + weight_steps(neuron, i) * `WEIGHT_SCALE * int'(pixels[i]);
  end
  // Full sum taken modulo 2^ACC_WIDTH
  wrapped = sum[`ACC_WIDTH-1:0];
  if (wrapped[`ACC_WIDTH-1])
  begin
    return '0;
  end
  return layer0_pkg::acc_t'(wrapped);
endfunction

function automatic layer0_pkg::layer_out_t model_layer(input layer0_pkg::image_t pixels);
  layer0_pkg::layer_out_t out;
  out.n2  = model_neuron(0, pixels);
  out.n5  = model_neuron(1, pixels);
  out.n10 = model_neuron(2, pixels);
  out.n15 = model_neuron(3, pixels);
  return out;
endfunction

`endif

/* test/layer0_dense_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "layer0_settings.svh"

module layer0_dense_tb;

  `include "layer0_model.svh"

  typedef enum logic [1:0] {
    kind_zero,
    kind_impulse,
    kind_fill,
    kind_random
  } img_kind_e;

  typedef struct packed {
    img_kind_e         kind;
    logic [7:0]        index;
    logic signed [7:0] value;
    logic              valid;
    logic              check;
  } row_t;

  localparam int row_count    = 20;
  localparam int reset_cycles = 4;
  localparam int clk_period   = 100;

  // kind, pixel index, value, valid, check
  localparam row_t rows [row_count] = '{
    '{kind_zero,    8'd0,   8'h00, 1'b0, 1'b1},
    '{kind_impulse, 8'd42,  8'h01, 1'b1, 1'b1},
    '{kind_impulse, 8'd132, 8'hFF, 1'b1, 1'b1},
    '{kind_impulse, 8'd0,   8'h05, 1'b0, 1'b1},
    '{kind_impulse, 8'd61,  8'h03, 1'b1, 1'b1},
    '{kind_impulse, 8'd143, 8'hFE, 1'b1, 1'b1},
    '{kind_impulse, 8'd1,   8'h64, 1'b0, 1'b1},
    '{kind_impulse, 8'd69,  8'hFC, 1'b1, 1'b1},
    '{kind_impulse, 8'd11,  8'hF9, 1'b1, 1'b1},
    '{kind_random,  8'd0,   8'h00, 1'b1, 1'b1},
    '{kind_random,  8'd0,   8'h00, 1'b0, 1'b1},
    '{kind_random,  8'd0,   8'h00, 1'b1, 1'b1},
    '{kind_fill,    8'd0,   8'h7F, 1'b1, 1'b1},
    '{kind_fill,    8'd0,   8'h80, 1'b1, 1'b1},
    '{kind_random,  8'd0,   8'h00, 1'b1, 1'b0},
    '{kind_random,  8'd0,   8'h00, 1'b1, 1'b1},
    '{kind_impulse, 8'd119, 8'h7F, 1'b0, 1'b1},
    '{kind_fill,    8'd0,   8'hFF, 1'b1, 1'b1},
    '{kind_zero,    8'd0,   8'h00, 1'b1, 1'b1},
    '{kind_random,  8'd0,   8'h00, 1'b0, 1'b1}
  };

  logic                   clk;
  logic                   rst;
  logic                   valid;
  layer0_pkg::image_t     img;
  logic                   ready;
  layer0_pkg::layer_out_t layer_out;

  logic [31:0]            rng_state;
  int                     pass_count;
  int                     fail_count;
  int                     row_errors;
  layer0_pkg::layer_out_t expected;
  logic                   expected_ready;

  layer0_dense layer0_dense_i
  (
    .clk       (clk),
    .rst       (rst),
    .img       (img),
    .valid     (valid),
    .ready     (ready),
    .layer_out (layer_out)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic string kind_label(input img_kind_e kind);
    case (kind)
      kind_zero:    return "zero";
      kind_impulse: return "impulse";
      kind_fill:    return "fill";
      default:      return "random";
    endcase
  endfunction

  task automatic check_field(input string name, input logic [`ACC_WIDTH-1:0] want,
                             input logic [`ACC_WIDTH-1:0] got);
    assert (got === want)
    else
    begin
      $display("ERR %s expected %0h actual %0h", name, want, got);
      row_errors++;
    end
  endtask

  task automatic check_outputs(input logic want_ready, input layer0_pkg::layer_out_t want);
    row_errors = 0;
    check_field("ready", `ACC_WIDTH'(want_ready), `ACC_WIDTH'(ready));
    check_field("n2", want.n2, layer_out.n2);
    check_field("n5", want.n5, layer_out.n5);
    check_field("n10", want.n10, layer_out.n10);
    check_field("n15", want.n15, layer_out.n15);
    if (row_errors == 0)
    begin
      pass_count++;
    end
    else
    begin
      fail_count++;
    end
  endtask

  task automatic build_image(input row_t row, output layer0_pkg::image_t pixels);
    pixels = '0;
    for (int i = 0; i < `PIXEL_COUNT; i++)
    begin
      if (row.kind == kind_fill)
      begin
        pixels[i] = row.value;
      end
      else if (row.kind == kind_random)
      begin
        rng_state = xorshift(rng_state);
        pixels[i] = layer0_pkg::pixel_t'(rng_state[7:0]);
      end
    end
    if (row.kind == kind_impulse)
    begin
      pixels[row.index] = row.value;
    end
  endtask

  task automatic apply_row(input int r);
    layer0_pkg::image_t pixels;
    build_image(rows[r], pixels);
    img            = pixels;
    valid          = rows[r].valid;
    expected       = model_layer(pixels);
    expected_ready = rows[r].valid;
  endtask

  task automatic finish_row(input int r);
    if (rows[r].check)
    begin
      check_outputs(expected_ready, expected);
      $display("row %0d %s valid %b %s", r, kind_label(rows[r].kind), rows[r].valid,
               (row_errors == 0) ? "pass" : "mismatch");
    end
    else
    begin
      $display("row %0d %s valid %b not checked", r, kind_label(rows[r].kind), rows[r].valid);
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    // Full image and valid high while reset holds the buffer and ready clear
    valid      = 1'b1;
    img        = {`PIXEL_COUNT{8'h7F}};
    rng_state  = 32'h5000;
    pass_count = 0;
    fail_count = 0;
    row_errors = 0;

    for (int c = 0; c < reset_cycles; c++)
    begin
      @(negedge clk);
      check_outputs(1'b0, model_layer('0));
      $display("reset cycle %0d %s", c, (row_errors == 0) ? "pass" : "mismatch");
    end

    rst = 1'b0;
    apply_row(0);
    for (int r = 1; r <= row_count; r++)
    begin
      @(negedge clk);
      finish_row(r - 1);
      if (r < row_count)
      begin
        apply_row(r);
      end
    end
    valid = 1'b0;

    $display("checks passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

  initial
  begin
    #((reset_cycles + row_count + 20) * clk_period);
    $display("Watchdog timeout, the row sequence did not complete in time");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
+incdir+test
design/layer0_pkg.sv
design/pixel_buffer.sv
design/dense_neuron.sv
design/layer0_dense.sv
test/layer0_dense_tb.sv

/* run.sh */
#!/bin/sh
# Builds with Verilator, runs the testbench and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module layer0_dense_tb -f tb.f -o layer0_dense_tb \
  && ./obj_dir/layer0_dense_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0
